//--- mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////

// Instruction and data word
`define DATA_W 16

// External SRAM address bus
`define ADDR_W 16

// Architectural registers
`define NREGS 8

////////////////////////////////////////////////////////////
// SRAM timing
////////////////////////////////////////////////////////////

// Clocks spent in each of the three access phases
`define RAM_PHASE 2

`endif

//--- isa_pkg.sv
`default_nettype none

`include "mem_defs.svh"

package isa_pkg;

	// Major opcode in the top five bits of every word
	typedef enum logic [4:0] {
		LI = 5'b01101,
		LW = 5'b10011,
		SW = 5'b11011
	} opcode_t;

	typedef logic [$clog2(`NREGS)-1:0] reg_idx_t;

	// Load/store form: base register, data register, 5-bit offset
	typedef struct packed {
		opcode_t opcode;
		reg_idx_t rx;
		reg_idx_t ry;
		logic [4:0] imm5;
	} insn_rri_t;

	// Immediate form: destination register and 8-bit constant
	typedef struct packed {
		opcode_t opcode;
		reg_idx_t rx;
		logic [7:0] imm8;
	} insn_ri_t;

	// Same 16 bits, view picked by opcode
	typedef union packed {
		insn_rri_t rri;
		insn_ri_t ri;
	} insn_u;

endpackage

`default_nettype wire

//--- mem_pkg.sv
`default_nettype none

package mem_pkg;

	// SRAM sequencer, three phases per access
	typedef enum logic [2:0] {
		IDLE = 3'd0,
		RD1 = 3'd1,
		RD2 = 3'd2,
		RD3 = 3'd3,
		WR1 = 3'd4,
		WR2 = 3'd5,
		WR3 = 3'd6
	} ram_state_t;

	// Owner of the access in flight
	typedef enum logic {
		EXE = 1'b0,
		FETCH = 1'b1
	} src_t;

endpackage

`default_nettype wire

//--- lsu_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_defs.svh"

module lsu_decode (
	input wire clk,
	input wire rst,
	input wire in_valid,
	output logic in_ready,
	input wire [`DATA_W-1:0] in_insn,
	output logic dec_valid,
	input wire dec_ready,
	output isa_pkg::opcode_t dec_op,
	output isa_pkg::reg_idx_t dec_rx,
	output isa_pkg::reg_idx_t dec_ry,
	output logic [`DATA_W-1:0] dec_imm,
	output logic dec_illegal
);

	isa_pkg::insn_u word;
	logic is_li;
	logic known;
	logic [`DATA_W-1:0] imm;

	assign word = in_insn;
	assign is_li = (word.rri.opcode == isa_pkg::LI);
	assign known = word.rri.opcode inside {isa_pkg::LI, isa_pkg::LW, isa_pkg::SW};

	// LI takes imm8 as unsigned, loads and stores sign-extend imm5
	assign imm = is_li ? {{(`DATA_W-8){1'b0}}, word.ri.imm8}
		: {{(`DATA_W-5){word.rri.imm5[4]}}, word.rri.imm5};

	// Output register frees up when it is empty or being drained
	assign in_ready = !dec_valid || dec_ready;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			dec_valid <= 1'b0;
		end else if (in_ready) begin
			dec_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			dec_op <= word.rri.opcode;
			dec_rx <= word.rri.rx;
			dec_ry <= word.rri.ry;
			dec_imm <= imm;
			dec_illegal <= !known;
		end
	end

endmodule

`default_nettype wire

//--- lsu_execute.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_defs.svh"

module lsu_execute (
	input wire clk,
	input wire rst,
	input wire dec_valid,
	output logic dec_ready,
	input isa_pkg::opcode_t dec_op,
	input isa_pkg::reg_idx_t dec_rx,
	input isa_pkg::reg_idx_t dec_ry,
	input wire [`DATA_W-1:0] dec_imm,
	input wire dec_illegal,
	output logic exe_req,
	input wire exe_gnt,
	output logic exe_wr,
	output logic [`ADDR_W-1:0] exe_addr,
	output logic [`DATA_W-1:0] exe_wdata,
	input wire exe_done,
	input wire [`DATA_W-1:0] exe_rdata,
	output logic ex_valid,
	input wire ex_ready,
	output isa_pkg::reg_idx_t ex_reg,
	output logic [`DATA_W-1:0] ex_data,
	output logic ex_wr,
	output logic ex_illegal,
	input wire wb_en,
	input isa_pkg::reg_idx_t wb_reg,
	input wire [`DATA_W-1:0] wb_data
);

	typedef enum logic [1:0] {M_IDLE, M_REQ, M_WAIT, M_HOLD} mem_st_t;

	mem_st_t mst;
	logic [`DATA_W-1:0] regs [`NREGS];
	logic [`NREGS-1:0] pend;
	isa_pkg::reg_idx_t dst_q;
	logic is_mem;
	logic is_sw;
	logic srcs_free;
	logic out_free;
	logic issue_direct;
	logic mem_finish;
	logic load_ex;
	isa_pkg::reg_idx_t nx_reg;
	logic [`DATA_W-1:0] nx_data;
	logic nx_wr;
	logic nx_illegal;

	assign is_mem = !dec_illegal && (dec_op == isa_pkg::LW || dec_op == isa_pkg::SW);
	assign is_sw = is_mem && (dec_op == isa_pkg::SW);

	// Hazard check on the registers the word actually reads
	assign srcs_free = !((is_mem && pend[dec_rx]) || (is_sw && pend[dec_ry]));
	assign out_free = !ex_valid || ex_ready;

	// Memory ops do not need the output slot until their data is back
	assign dec_ready = (mst == M_IDLE) && srcs_free && (is_mem || out_free);
	assign issue_direct = dec_valid && dec_ready && !is_mem;
	assign mem_finish = ((mst == M_WAIT && exe_done) || mst == M_HOLD) && out_free;
	assign load_ex = issue_direct || mem_finish;
	assign exe_req = (mst == M_REQ);

	always_comb begin
		if (issue_direct) begin
			nx_reg = dec_rx;
			nx_data = dec_illegal ? '0 : dec_imm;
			nx_wr = !dec_illegal;
			nx_illegal = dec_illegal;
		end else begin
			nx_reg = dst_q;
			nx_data = exe_wr ? exe_wdata : exe_rdata;
			nx_wr = !exe_wr;
			nx_illegal = 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Memory op sequencing
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			mst <= M_IDLE;
		end else begin
			case (mst)
				M_IDLE: if (dec_valid && dec_ready && is_mem) mst <= M_REQ;
				M_REQ: if (exe_gnt) mst <= M_WAIT;
				M_WAIT: if (exe_done) mst <= out_free ? M_IDLE : M_HOLD;
				M_HOLD: if (out_free) mst <= M_IDLE;
				default: mst <= M_IDLE;
			endcase
		end
	end

	// Address is base plus offset, captured once at issue
	always_ff @(posedge clk) begin
		if (dec_valid && dec_ready && is_mem) begin
			exe_wr <= is_sw;
			exe_addr <= `ADDR_W'(regs[dec_rx] + dec_imm);
			exe_wdata <= regs[dec_ry];
			dst_q <= dec_ry;
		end
	end

	////////////////////////////////////////////////////////////
	// Register file and scoreboard
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pend <= '0;
			for (int i = 0; i < `NREGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (wb_en) begin
				regs[wb_reg] <= wb_data;
				pend[wb_reg] <= 1'b0;
			end
			// A new writer of the same register keeps it busy
			if (load_ex && nx_wr) pend[nx_reg] <= 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ex_valid <= 1'b0;
		end else if (load_ex) begin
			ex_valid <= 1'b1;
		end else if (ex_ready) begin
			ex_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load_ex) begin
			ex_reg <= nx_reg;
			ex_data <= nx_data;
			ex_wr <= nx_wr;
			ex_illegal <= nx_illegal;
		end
	end

	// Controller may sample the request on any cycle before it grants
	a_req_stable: assert property (@(posedge clk) disable iff (!rst)
		exe_req && !exe_gnt |=> $stable(exe_addr) && $stable(exe_wr));

endmodule

`default_nettype wire

//--- sram_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_defs.svh"

module sram_ctrl (
	input wire clk,
	input wire rst,
	input wire exe_req,
	output logic exe_gnt,
	input wire exe_wr,
	input wire [`ADDR_W-1:0] exe_addr,
	input wire [`DATA_W-1:0] exe_wdata,
	output logic exe_done,
	output logic [`DATA_W-1:0] exe_rdata,
	input wire fetch_valid,
	output logic fetch_ready,
	input wire [`ADDR_W-1:0] fetch_addr,
	output logic fetch_done,
	output logic [`DATA_W-1:0] fetch_data,
	output logic [`ADDR_W-1:0] ram_addr,
	inout wire [`DATA_W-1:0] ram_data,
	output logic ram_en,
	output logic ram_oe,
	output logic ram_we
);

	localparam int CNT_W = $clog2(`RAM_PHASE + 1);

	mem_pkg::ram_state_t state;
	mem_pkg::ram_state_t next_phase;
	mem_pkg::src_t src;
	logic [CNT_W-1:0] cnt;
	logic phase_end;
	logic [`DATA_W-1:0] wdata_q;
	logic bus_drive;

	// Execute always wins, fetch only gets an idle bus
	assign exe_gnt = (state == mem_pkg::IDLE) && exe_req;
	assign fetch_ready = (state == mem_pkg::IDLE) && !exe_req;
	assign phase_end = (cnt == CNT_W'(`RAM_PHASE - 1));

	always_comb begin
		case (state)
			mem_pkg::RD1: next_phase = mem_pkg::RD2;
			mem_pkg::RD2: next_phase = mem_pkg::RD3;
			mem_pkg::WR1: next_phase = mem_pkg::WR2;
			mem_pkg::WR2: next_phase = mem_pkg::WR3;
			default: next_phase = mem_pkg::IDLE;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Phase sequencer
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= mem_pkg::IDLE;
			src <= mem_pkg::EXE;
			cnt <= '0;
			exe_done <= 1'b0;
			fetch_done <= 1'b0;
		end else begin
			exe_done <= phase_end && ((state == mem_pkg::RD3 && src == mem_pkg::EXE)
				|| state == mem_pkg::WR3);
			fetch_done <= phase_end && state == mem_pkg::RD3 && src == mem_pkg::FETCH;
			if (state == mem_pkg::IDLE || phase_end) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
			if (state == mem_pkg::IDLE) begin
				if (exe_req) begin
					state <= exe_wr ? mem_pkg::WR1 : mem_pkg::RD1;
					src <= mem_pkg::EXE;
				end else if (fetch_valid) begin
					state <= mem_pkg::RD1;
					src <= mem_pkg::FETCH;
				end
			end else if (phase_end) begin
				state <= next_phase;
			end
		end
	end

	// Latch address at grant, read data at the close of RD3
	always_ff @(posedge clk) begin
		if (exe_gnt) begin
			ram_addr <= exe_addr;
			wdata_q <= exe_wdata;
		end else if (fetch_ready && fetch_valid) begin
			ram_addr <= fetch_addr;
		end
		if (phase_end && state == mem_pkg::RD3) begin
			if (src == mem_pkg::EXE) begin
				exe_rdata <= ram_data;
			end else begin
				fetch_data <= ram_data;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// SRAM pins
	////////////////////////////////////////////////////////////

	// Chip stays selected, OE and WE do the work
	assign ram_en = 1'b0;
	assign ram_oe = !(state inside {mem_pkg::RD1, mem_pkg::RD2, mem_pkg::RD3});
	assign ram_we = (state != mem_pkg::WR2);
	assign bus_drive = state inside {mem_pkg::WR1, mem_pkg::WR2, mem_pkg::WR3};
	assign ram_data = bus_drive ? wdata_q : 'z;

	a_oe_we: assert property (@(posedge clk) disable iff (!rst) !(!ram_oe && !ram_we));
	a_no_fight: assert property (@(posedge clk) disable iff (!rst) bus_drive |-> ram_oe);

endmodule

`default_nettype wire

//--- lsu_result.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_defs.svh"

module lsu_result (
	input wire clk,
	input wire rst,
	input wire ex_valid,
	output logic ex_ready,
	input isa_pkg::reg_idx_t ex_reg,
	input wire [`DATA_W-1:0] ex_data,
	input wire ex_wr,
	input wire ex_illegal,
	output logic wb_en,
	output isa_pkg::reg_idx_t wb_reg,
	output logic [`DATA_W-1:0] wb_data,
	output logic res_valid,
	input wire res_ready,
	output isa_pkg::reg_idx_t res_reg,
	output logic [`DATA_W-1:0] res_data,
	output logic res_wr,
	output logic res_illegal
);

	assign ex_ready = !res_valid || res_ready;

	// Register write happens on the entry edge itself
	assign wb_en = ex_valid && ex_ready && ex_wr;
	assign wb_reg = ex_reg;
	assign wb_data = ex_data;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			res_valid <= 1'b0;
		end else if (ex_ready) begin
			res_valid <= ex_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (ex_valid && ex_ready) begin
			res_reg <= ex_reg;
			res_data <= ex_data;
			res_wr <= ex_wr;
			res_illegal <= ex_illegal;
		end
	end

endmodule

`default_nettype wire

//--- lsu_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_defs.svh"

module lsu_top (
	input wire clk,
	input wire rst,
	input wire in_valid,
	output logic in_ready,
	input wire [`DATA_W-1:0] in_insn,
	output logic res_valid,
	input wire res_ready,
	output isa_pkg::reg_idx_t res_reg,
	output logic [`DATA_W-1:0] res_data,
	output logic res_wr,
	output logic res_illegal,
	input wire fetch_valid,
	output logic fetch_ready,
	input wire [`ADDR_W-1:0] fetch_addr,
	output logic fetch_done,
	output logic [`DATA_W-1:0] fetch_data,
	output logic [`ADDR_W-1:0] ram_addr,
	inout wire [`DATA_W-1:0] ram_data,
	output logic ram_en,
	output logic ram_oe,
	output logic ram_we
);

	// Decode to execute
	logic dec_valid;
	logic dec_ready;
	isa_pkg::opcode_t dec_op;
	isa_pkg::reg_idx_t dec_rx;
	isa_pkg::reg_idx_t dec_ry;
	logic [`DATA_W-1:0] dec_imm;
	logic dec_illegal;

	// Execute to SRAM controller
	logic exe_req;
	logic exe_gnt;
	logic exe_wr;
	logic [`ADDR_W-1:0] exe_addr;
	logic [`DATA_W-1:0] exe_wdata;
	logic exe_done;
	logic [`DATA_W-1:0] exe_rdata;

	// Execute to result, and write-back
	logic ex_valid;
	logic ex_ready;
	isa_pkg::reg_idx_t ex_reg;
	logic [`DATA_W-1:0] ex_data;
	logic ex_wr;
	logic ex_illegal;
	logic wb_en;
	isa_pkg::reg_idx_t wb_reg;
	logic [`DATA_W-1:0] wb_data;

	lsu_decode u_decode (.*);

	lsu_execute u_execute (.*);

	sram_ctrl u_sram_ctrl (.*);

	lsu_result u_result (.*);

endmodule

`default_nettype wire

//--- tb_sram.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_defs.svh"

module tb_sram (
	input wire [`ADDR_W-1:0] addr,
	inout wire [`DATA_W-1:0] data,
	input wire en,
	input wire oe,
	input wire we
);

	logic [`DATA_W-1:0] mem [2**`ADDR_W];

	// Drives the bus only while selected, OE low and WE high
	assign data = (!en && !oe && we) ? mem[addr] : 'z;

	// Write completes as WE rises
	always @(posedge we) begin
		if (!en && !$isunknown(addr)) begin
			mem[addr] <= data;
		end
	end

endmodule

`default_nettype wire

//--- tb_lsu.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_defs.svh"

module tb_lsu;

	localparam int N_INSN = 300;
	localparam int MAX_CYCLES = N_INSN * (3 * `RAM_PHASE + 4) * 4;

	// Kinds of expected result
	localparam int K_LI = 0;
	localparam int K_LW = 1;
	localparam int K_SW = 2;
	localparam int K_BAD = 3;

	logic clk;
	logic rst;
	logic in_valid;
	logic in_ready;
	logic [`DATA_W-1:0] in_insn;
	logic res_valid;
	logic res_ready;
	isa_pkg::reg_idx_t res_reg;
	logic [`DATA_W-1:0] res_data;
	logic res_wr;
	logic res_illegal;
	logic fetch_valid;
	logic fetch_ready;
	logic [`ADDR_W-1:0] fetch_addr;
	logic fetch_done;
	logic [`DATA_W-1:0] fetch_data;
	logic [`ADDR_W-1:0] ram_addr;
	wire [`DATA_W-1:0] ram_data;
	logic ram_en;
	logic ram_oe;
	logic ram_we;

	integer seed;
	int errors;
	int sent;
	int seen;
	int cycles;
	logic running;
	logic [`DATA_W-1:0] next_word;
	logic [14:0] next_fetch;

	// Reference state
	logic [`DATA_W-1:0] model_regs [`NREGS];
	logic [`DATA_W-1:0] model_mem [2**`ADDR_W];
	int exp_kind [$];
	logic [2:0] exp_reg [$];
	logic [`DATA_W-1:0] exp_data [$];
	logic [`DATA_W-1:0] fetch_exp [$];

	lsu_top uut (.*);

	tb_sram u_ram (
		.addr(ram_addr),
		.data(ram_data),
		.en(ram_en),
		.oe(ram_oe),
		.we(ram_we)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	// Byte swap and scramble, so every address bit matters
	function automatic logic [`DATA_W-1:0] fill_word(input logic [`ADDR_W-1:0] a);
		return {a[7:0], a[15:8]} ^ 16'h3c5a;
	endfunction

	task automatic abort_run();
		errors++;
		$display("Errors found");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic push_expect(input int kind, input logic [2:0] r, input logic [15:0] d);
		exp_kind.push_back(kind);
		exp_reg.push_back(r);
		exp_data.push_back(d);
	endtask

	// Executes one accepted word in program order
	task automatic model_step(input logic [`DATA_W-1:0] w);
		logic [4:0] op;
		logic [2:0] rx;
		logic [2:0] ry;
		logic [`ADDR_W-1:0] addr;
		op = w[15:11];
		rx = w[10:8];
		ry = w[7:5];
		addr = model_regs[rx] + {{11{w[4]}}, w[4:0]};
		if (op == isa_pkg::LI) begin
			model_regs[rx] = {8'h00, w[7:0]};
			push_expect(K_LI, rx, model_regs[rx]);
		end else if (op == isa_pkg::LW) begin
			model_regs[ry] = model_mem[addr];
			push_expect(K_LW, ry, model_regs[ry]);
		end else if (op == isa_pkg::SW) begin
			model_mem[addr] = model_regs[ry];
			push_expect(K_SW, ry, model_regs[ry]);
		end else begin
			push_expect(K_BAD, rx, '0);
		end
	endtask

	task automatic make_insn(output logic [`DATA_W-1:0] w);
		logic [31:0] sel;
		logic [31:0] fld;
		logic [4:0] op;
		logic [`ADDR_W-1:0] addr;
		sel = $random(seed);
		fld = $random(seed);
		case (sel[2:0])
			3'd0, 3'd1, 3'd2: op = isa_pkg::LI;
			3'd3, 3'd4: op = isa_pkg::LW;
			3'd5, 3'd6: op = isa_pkg::SW;
			default: begin
				op = sel[31:27];
				while (op inside {isa_pkg::LI, isa_pkg::LW, isa_pkg::SW}) begin
					op = op + 5'd1;
				end
			end
		endcase
		w = {op, fld[10:0]};
		// Stores stay below 0x8000 and leave the fetch window above untouched
		addr = model_regs[w[10:8]] + {{11{w[4]}}, w[4:0]};
		if (op == isa_pkg::SW && addr[15]) begin
			w = {5'(isa_pkg::LI), fld[10:0]};
		end
	endtask

	task automatic check_result();
		int kind;
		logic [2:0] r;
		logic [15:0] d;
		if (exp_kind.size() == 0) begin
			$display("A result came out with no instruction outstanding at %0t ns", $time);
			abort_run();
		end else begin
			kind = exp_kind.pop_front();
			r = exp_reg.pop_front();
			d = exp_data.pop_front();
			check_value("res_illegal", res_illegal, kind == K_BAD);
			check_value("res_wr", res_wr, kind == K_LI || kind == K_LW);
			if (kind != K_BAD) begin
				check_value("res_reg", res_reg, r);
				check_value("res_data", res_data, d);
			end
			seen++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus and monitors
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (running) begin
			if (in_valid && in_ready) begin
				model_step(in_insn);
				sent++;
			end
			if (!in_valid || in_ready) begin
				if (sent < N_INSN && ($random(seed) & 3) != 0) begin
					make_insn(next_word);
					in_valid <= 1'b1;
					in_insn <= next_word;
				end else begin
					in_valid <= 1'b0;
				end
			end

			if (res_valid && res_ready) begin
				check_result();
			end
			res_ready <= ($random(seed) & 3) != 0;

			if (fetch_valid && fetch_ready) begin
				fetch_exp.push_back(model_mem[fetch_addr]);
			end
			if (!fetch_valid || fetch_ready) begin
				if (sent < N_INSN && ($random(seed) & 7) == 0) begin
					next_fetch = $random(seed);
					fetch_valid <= 1'b1;
					fetch_addr <= {1'b1, next_fetch};
				end else begin
					fetch_valid <= 1'b0;
				end
			end
			if (fetch_done) begin
				if (fetch_exp.size() == 0) begin
					$display("fetch_done pulsed with no fetch outstanding at %0t ns", $time);
					abort_run();
				end else begin
					check_value("fetch_data", fetch_data, fetch_exp.pop_front());
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
			abort_run();
		end
	end

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		seed = 32'h85b3_306d;
		errors = 0;
		sent = 0;
		seen = 0;
		cycles = 0;
		running = 1'b0;
		rst = 1'b0;
		in_valid = 1'b0;
		in_insn = '0;
		res_ready = 1'b0;
		fetch_valid = 1'b0;
		fetch_addr = '0;
		for (int a = 0; a < 2**`ADDR_W; a++) begin
			model_mem[a] = fill_word(16'(a));
			u_ram.mem[a] = fill_word(16'(a));
		end
		for (int i = 0; i < `NREGS; i++) begin
			model_regs[i] = '0;
		end

		repeat (5) @(posedge clk);
		rst <= 1'b1;
		@(posedge clk);
		check_value("ram_en after reset", ram_en, 1'b0);
		check_value("ram_oe after reset", ram_oe, 1'b1);
		check_value("ram_we after reset", ram_we, 1'b1);
		check_value("res_valid after reset", res_valid, 1'b0);
		check_value("fetch_done after reset", fetch_done, 1'b0);
		running <= 1'b1;

		while (seen < N_INSN || fetch_valid || fetch_exp.size() != 0) begin
			@(negedge clk);
		end
		// Extra results or fetch pulses would show up here
		repeat (10) @(negedge clk);

		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
isa_pkg.sv
mem_pkg.sv
lsu_decode.sv
lsu_execute.sv
sram_ctrl.sv
lsu_result.sv
lsu_top.sv
tb_sram.sv
tb_lsu.sv
